// ==== src/fetchPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared definitions for the fetch subsystem
// width, reset vector, bubble encoding and next-PC select type
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package fetchPkg;

  // architectural width, fixed for this core
  localparam int Xlen = 32;

  // every PC, target and link address
  typedef logic [Xlen-1:0] addrT;

  // instruction word, always 32 bits even with RVC
  typedef logic [31:0] instrT;

  // first fetch address after reset, one word
  localparam addrT ResetVector = 32'h0000_1000;

  // addi x0,x0,0
  // doubles as the bubble in the instruction pipe
  localparam instrT NopInstr = 32'h0000_0013;

  // next-PC source, lowest to highest priority
  typedef enum logic [1:0] {
    PcSeq,
    PcBranch,
    PcPriv
  } pcSrcT;

endpackage

`default_nettype wire

// ==== src/pipeCtrlIf.sv ====
////////////////////////////////////////////////////////////////////////////
// pipeline stall and flush levels from the hazard unit
// ctrl modport drives, fetch modport receives
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface pipeCtrlIf;

  // per-stage hold
  logic stallF, stallD, stallE, stallM, stallW;

  // per-stage bubble insert, fetch has no flush
  logic flushD, flushE, flushM, flushW;

  // hazard side, levels only, no handshake
  modport ctrl (
    output stallF, stallD, stallE, stallM, stallW,
    output flushD, flushE, flushM, flushW
  );

  // fetch unit side, sampled at each rising clk
  modport fetch (
    input stallF, stallD, stallE, stallM, stallW,
    input flushD, flushE, flushM, flushW
  );

endinterface

`default_nettype wire

// ==== src/pcSelect.sv ====
////////////////////////////////////////////////////////////////////////////
// next-PC mux and PC register
// PC+2 / PC+4 adder, halfword alignment, misaligned target flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pcSelect import fetchPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  stall,
  input  pcSrcT src,
  input  addrT  branchTarget,
  input  addrT  privTarget,
  input  logic  compressed,
  output addrT  pcF,
  output addrT  pcPlus2or4F,
  output addrT  nextPc,
  output logic  misalignedNext
);

  // selection before bit 0 is forced low
  addrT             unalignedNext;
  // word index of the following word
  logic [Xlen-3:0]  pcUpper;

  ////////////////////////////////////////////////////////////////////////////
  // sequential address
  ////////////////////////////////////////////////////////////////////////////

  assign pcUpper = pcF[Xlen-1:2] + 1'b1;

  always_comb begin
    if (compressed) begin
      // +2, carries into the word index when sitting on the upper half
      if (pcF[1]) begin
        pcPlus2or4F = {pcUpper, 2'b00};
      end else begin
        pcPlus2or4F = {pcF[Xlen-1:2], 2'b10};
      end
    end else begin
      // +4 keeps the halfword offset
      pcPlus2or4F = {pcUpper, pcF[1:0]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // redirect mux and PC register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (src)
      PcPriv:   unalignedNext = privTarget;
      PcBranch: unalignedNext = branchTarget;
      default:  unalignedNext = pcPlus2or4F;
    endcase
  end

  // RVC allows halfword targets, so only bit 0 is dropped
  assign nextPc         = {unalignedNext[Xlen-1:1], 1'b0};
  assign misalignedNext = unalignedNext[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= ResetVector;
    end else if (!stall) begin
      pcF <= nextPc;
    end
  end

endmodule

`default_nettype wire

// ==== src/instrAlign.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction extraction from the 32-bit fetch word
// joins the spill halfword for instructions crossing a word boundary
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module instrAlign import fetchPkg::*; (
  // PC bit 1, halfword offset inside the word
  input  logic        pcLow,
  // aligned word at PC with bits 1:0 cleared
  input  instrT       instrWord,
  // low half of the next word, same cycle
  input  logic [15:0] spillHalf,
  output instrT       instrF
);

  // upper half of the current word as a 16-bit view
  logic [15:0] upperHalf;

  assign upperHalf = instrWord[31:16];

  // on the upper halfword the instruction starts there
  // a compressed one only uses the low 16 bits of the result,
  // a 32-bit one takes its top half from the next word
  always_comb begin
    if (pcLow) begin
      instrF = {spillHalf, upperHalf};
    end else begin
      instrF = instrWord;
    end
  end

endmodule

`default_nettype wire

// ==== src/decompress.sv ====
////////////////////////////////////////////////////////////////////////////
// RVC expander for the decode stage
// integer subset of quadrants 0..2, illegal encodings become a NOP
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module decompress import fetchPkg::*; (
  input  instrT instrRaw,
  output instrT instrD,
  output logic  illegalCompD
);

  // common RVC fields
  logic [1:0]  quadrant;
  logic [2:0]  funct3;
  logic [4:0]  rdFull;
  logic [4:0]  rs2Full;
  // 3-bit register fields map to x8..x15
  logic [4:0]  rs1p;
  logic [4:0]  rdp;
  // scaled word offset for c.lw / c.sw
  logic [11:0] lwOff;
  // sign-extended 6-bit immediate
  logic [11:0] imm6;
  // jump and branch offsets, bit 0 always zero
  logic [11:0] jOff;
  logic [8:0]  bOff;

  assign quadrant = instrRaw[1:0];
  assign funct3   = instrRaw[15:13];
  assign rdFull   = instrRaw[11:7];
  assign rs2Full  = instrRaw[6:2];
  assign rs1p     = {2'b01, instrRaw[9:7]};
  assign rdp      = {2'b01, instrRaw[4:2]};

  // uimm[6|5:3|2] scaled by 4
  assign lwOff = {5'b0, instrRaw[5], instrRaw[12:10], instrRaw[6], 2'b00};
  assign imm6  = {{7{instrRaw[12]}}, instrRaw[6:2]};

  // c.j offset[11|4|9:8|10|6|7|3:1|5]
  assign jOff = {instrRaw[12], instrRaw[8], instrRaw[10:9], instrRaw[6],
                 instrRaw[7], instrRaw[2], instrRaw[11], instrRaw[5:3], 1'b0};

  // c.beqz/c.bnez offset[8|4:3|7:6|2:1|5]
  assign bOff = {instrRaw[12], instrRaw[6:5], instrRaw[2], instrRaw[11:10],
                 instrRaw[4:3], 1'b0};

  always_comb begin
    // anything not matched below is illegal
    instrD       = NopInstr;
    illegalCompD = 1'b1;

    case (quadrant)
      ////////////////////////////////////////////////////////////////////////////
      // quadrant 0, loads and stores
      ////////////////////////////////////////////////////////////////////////////
      2'b00: begin
        // c.lw -> lw rd', off(rs1')
        if (funct3 == 3'b010) begin
          instrD       = {lwOff, rs1p, 3'b010, rdp, 7'b0000011};
          illegalCompD = 1'b0;
        end
        // c.sw -> sw rs2', off(rs1')
        if (funct3 == 3'b110) begin
          instrD       = {lwOff[11:5], rdp, rs1p, 3'b010, lwOff[4:0], 7'b0100011};
          illegalCompD = 1'b0;
        end
        // all-zero halfword is defined illegal, also falls out of c.addi4spn
        if (instrRaw[15:0] == 16'h0000) begin
          instrD       = NopInstr;
          illegalCompD = 1'b1;
        end
      end

      ////////////////////////////////////////////////////////////////////////////
      // quadrant 1, immediates and control flow
      ////////////////////////////////////////////////////////////////////////////
      2'b01: begin
        case (funct3)
          // c.addi / c.nop -> addi rd, rd, imm
          3'b000: begin
            instrD       = {imm6, rdFull, 3'b000, rdFull, 7'b0010011};
            illegalCompD = 1'b0;
          end
          // c.li -> addi rd, x0, imm
          3'b010: begin
            instrD       = {imm6, 5'b0, 3'b000, rdFull, 7'b0010011};
            illegalCompD = 1'b0;
          end
          // c.lui, x2 is c.addi16sp and a zero immediate is reserved
          3'b011: begin
            if (rdFull != 5'd2 && imm6 != 12'h000) begin
              instrD       = {{15{instrRaw[12]}}, instrRaw[6:2], rdFull, 7'b0110111};
              illegalCompD = 1'b0;
            end
          end
          // c.j -> jal x0, off
          3'b101: begin
            instrD       = {jOff[11], jOff[10:1], jOff[11], {8{jOff[11]}},
                            5'b0, 7'b1101111};
            illegalCompD = 1'b0;
          end
          // c.beqz / c.bnez -> beq/bne rs1', x0, off
          3'b110, 3'b111: begin
            instrD       = {bOff[8], {2{bOff[8]}}, bOff[8:5], 5'b0, rs1p,
                            {2'b00, funct3[0]}, bOff[4:1], bOff[8], 7'b1100011};
            illegalCompD = 1'b0;
          end
          default: ;
        endcase
      end

      ////////////////////////////////////////////////////////////////////////////
      // quadrant 2, register moves and jr
      ////////////////////////////////////////////////////////////////////////////
      2'b10: begin
        if (funct3 == 3'b100) begin
          if (!instrRaw[12]) begin
            if (rs2Full == 5'd0) begin
              // c.jr -> jalr x0, 0(rs1), rs1 of x0 is reserved
              if (rdFull != 5'd0) begin
                instrD       = {12'h000, rdFull, 3'b000, 5'b0, 7'b1100111};
                illegalCompD = 1'b0;
              end
            end else begin
              // c.mv -> add rd, x0, rs2
              instrD       = {7'b0, rs2Full, 5'b0, 3'b000, rdFull, 7'b0110011};
              illegalCompD = 1'b0;
            end
          end else if (rs2Full != 5'd0) begin
            // c.add -> add rd, rd, rs2
            // c.jalr and c.ebreak are not handled here
            instrD       = {7'b0, rs2Full, rdFull, 3'b000, rdFull, 7'b0110011};
            illegalCompD = 1'b0;
          end
        end
      end

      // full-width instruction, untouched
      default: begin
        instrD       = instrRaw;
        illegalCompD = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/stagePipe.sv ====
////////////////////////////////////////////////////////////////////////////
// E/M/W payload carrier, one register per stage
// per-stage enable, flush loads the bubble value
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module stagePipe #(
  parameter type T      = logic,
  parameter T    Bubble = '0
) (
  input  logic clk,
  input  logic rst,
  // payload leaving decode
  input  T     inD,
  // enables are the inverted stage stalls
  input  logic enE,
  input  logic enM,
  input  logic enW,
  input  logic flushE,
  input  logic flushM,
  input  logic flushW,
  output T     outE,
  output T     outM,
  output T     outW
);

  // stall beats flush, flush beats the upstream value

  always_ff @(posedge clk) begin
    if (rst) begin
      outE <= Bubble;
    end else if (enE) begin
      outE <= flushE ? Bubble : inD;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outM <= Bubble;
    end else if (enM) begin
      outM <= flushM ? Bubble : outE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outW <= Bubble;
    end else if (enW) begin
      outW <= flushW ? Bubble : outM;
    end
  end

endmodule

`default_nettype wire

// ==== src/ifu.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction fetch unit
// PC selection, alignment, decode register, RVC expansion,
// E/M/W payload pipes and the M-stage misaligned fault
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ifu import fetchPkg::*; (
  input  logic        clk,
  input  logic        rst,
  pipeCtrlIf.fetch    ctl,
  // fetch memory
  input  instrT       instrWord,
  input  logic [15:0] spillHalf,
  // redirects
  input  logic        pcSrcE,
  input  logic        retM,
  input  logic        trapM,
  input  addrT        pcTargetE,
  input  addrT        privNextPcM,
  input  logic        illegalBaseD,
  output addrT        pcF,
  output addrT        pcE,
  output addrT        pcM,
  output addrT        pcLinkW,
  output instrT       instrD,
  output instrT       instrM,
  output logic        illegalInstrD,
  output logic        instrMisalignedFaultM,
  output addrT        instrMisalignedAdrM
);

  pcSrcT src;
  addrT  pcPlus2or4F;
  addrT  nextPc;
  logic  misalignedNext;
  logic  compressedF;
  instrT instrF;
  // decode register
  instrT instrRawD;
  addrT  pcD;
  addrT  pcLinkD;
  logic  illegalCompD;

  ////////////////////////////////////////////////////////////////////////////
  // fetch stage
  ////////////////////////////////////////////////////////////////////////////

  // privileged change wins over a branch in the same cycle
  always_comb begin
    if (retM || trapM) begin
      src = PcPriv;
    end else if (pcSrcE) begin
      src = PcBranch;
    end else begin
      src = PcSeq;
    end
  end

  // 16-bit when the low bits are not 11
  assign compressedF = (instrF[1:0] != 2'b11);

  pcSelect pcSel (
    .clk(clk), .rst(rst), .stall(ctl.stallF), .src(src),
    .branchTarget(pcTargetE), .privTarget(privNextPcM),
    .compressed(compressedF), .pcF(pcF), .pcPlus2or4F(pcPlus2or4F),
    .nextPc(nextPc), .misalignedNext(misalignedNext)
  );

  instrAlign align (
    .pcLow(pcF[1]), .instrWord(instrWord), .spillHalf(spillHalf), .instrF(instrF)
  );

  ////////////////////////////////////////////////////////////////////////////
  // decode stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || (!ctl.stallD && ctl.flushD)) begin
      instrRawD <= NopInstr;
      pcD       <= '0;
      pcLinkD   <= '0;
    end else if (!ctl.stallD) begin
      instrRawD <= instrF;
      pcD       <= pcF;
      pcLinkD   <= pcPlus2or4F;
    end
  end

  decompress decomp (.instrRaw(instrRawD), .instrD(instrD), .illegalCompD(illegalCompD));

  // bad 32-bit encoding from the decoder or bad 16-bit one from here
  assign illegalInstrD = illegalBaseD | illegalCompD;

  ////////////////////////////////////////////////////////////////////////////
  // E/M/W payloads
  ////////////////////////////////////////////////////////////////////////////

  stagePipe #(.T(instrT), .Bubble(NopInstr)) instrPipe (
    .clk(clk), .rst(rst), .inD(instrD),
    .enE(!ctl.stallE), .enM(!ctl.stallM), .enW(!ctl.stallW),
    .flushE(ctl.flushE), .flushM(ctl.flushM), .flushW(ctl.flushW),
    .outE(), .outM(instrM), .outW()
  );

  stagePipe #(.T(addrT), .Bubble('0)) pcPipe (
    .clk(clk), .rst(rst), .inD(pcD),
    .enE(!ctl.stallE), .enM(!ctl.stallM), .enW(!ctl.stallW),
    .flushE(ctl.flushE), .flushM(ctl.flushM), .flushW(ctl.flushW),
    .outE(pcE), .outM(pcM), .outW()
  );

  // link address for jal/jalr writeback
  stagePipe #(.T(addrT), .Bubble('0)) linkPipe (
    .clk(clk), .rst(rst), .inD(pcLinkD),
    .enE(!ctl.stallE), .enM(!ctl.stallM), .enW(!ctl.stallW),
    .flushE(ctl.flushE), .flushM(ctl.flushM), .flushW(ctl.flushW),
    .outE(), .outM(), .outW(pcLinkW)
  );

  ////////////////////////////////////////////////////////////////////////////
  // misaligned branch target reported in M
  ////////////////////////////////////////////////////////////////////////////

  // only a selected branch redirect counts and trap targets are never flagged
  always_ff @(posedge clk) begin
    if (rst) begin
      instrMisalignedFaultM <= 1'b0;
    end else if (!ctl.stallM) begin
      instrMisalignedFaultM <= misalignedNext & (src == PcBranch);
    end
  end

  // aligned target goes out with the fault
  always_ff @(posedge clk) begin
    if (!ctl.stallM) begin
      instrMisalignedAdrM <= nextPc;
    end
  end

endmodule

`default_nettype wire

// ==== src/fetchTop.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch subsystem top level, plain ports only
// builds the stall/flush bundle and instantiates the fetch unit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetchTop import fetchPkg::*; (
  input  logic        clk,
  input  logic        rst,
  // hazard unit levels
  input  logic        stallF, stallD, stallE, stallM, stallW,
  input  logic        flushD, flushE, flushM, flushW,
  // instruction memory, combinational read at pcF
  input  instrT       instrWord,
  input  logic [15:0] spillHalf,
  // redirects from execute and the privileged unit
  input  logic        pcSrcE,
  input  logic        retM,
  input  logic        trapM,
  input  addrT        pcTargetE,
  input  addrT        privNextPcM,
  input  logic        illegalBaseD,
  output addrT        pcF,
  output addrT        pcE,
  output addrT        pcM,
  output addrT        pcLinkW,
  output instrT       instrD,
  output instrT       instrM,
  output logic        illegalInstrD,
  output logic        instrMisalignedFaultM,
  output addrT        instrMisalignedAdrM
);

  pipeCtrlIf ctl ();

  // bundle the hazard levels
  assign ctl.stallF = stallF;
  assign ctl.stallD = stallD;
  assign ctl.stallE = stallE;
  assign ctl.stallM = stallM;
  assign ctl.stallW = stallW;
  assign ctl.flushD = flushD;
  assign ctl.flushE = flushE;
  assign ctl.flushM = flushM;
  assign ctl.flushW = flushW;

  ifu fetch (.ctl(ctl.fetch), .*);

endmodule

`default_nettype wire

// ==== sim/fetchTb.sv ====
////////////////////////////////////////////////////////////////////////////
// directed testbench for the fetch subsystem
// instruction memory model, clock, reset, cycle limit, one task per behavior
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetchTb import fetchPkg::*; ();

  // the tests need a few hundred cycles at most
  localparam int   CycleLimit = 2000;
  // word used for the RVC expansion vectors
  localparam addrT DecAddr    = 32'h0000_1200;

  logic        clk, rst;
  logic        stallF, stallD, stallE, stallM, stallW;
  logic        flushD, flushE, flushM, flushW;
  instrT       instrWord;
  logic [15:0] spillHalf;
  logic        pcSrcE, retM, trapM, illegalBaseD;
  addrT        pcTargetE, privNextPcM;
  addrT        pcF, pcE, pcM, pcLinkW, instrMisalignedAdrM;
  instrT       instrD, instrM;
  logic        illegalInstrD, instrMisalignedFaultM;

  // 1 KiB window at ResetVector indexed by PC bits 9:2
  logic [31:0] mem [0:255];
  logic [31:0] rngState = 32'hd7db3606;
  int          cycles   = 0;

  // 32-bit, RVC, 32-bit across a word, RVC, RVC, 32-bit across a word
  instrT prog [0:5] = '{32'h00500093, 32'h00000085, 32'h00a00113,
                        32'h00004285, 32'h0000829a, 32'h002081b3};

  fetchTop dut (.*);

  // combinational read with the spill taken from the following word
  assign instrWord = mem[pcF[9:2]];
  assign spillHalf = mem[pcF[9:2] + 8'd1][15:0];

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("timeout, no end of test after %0d cycles", cycles);
      stopRun();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // xorshift32
  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic logic [15:0] halfAt(addrT a);
    logic [31:0] w;
    w = mem[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // RVC unless the low two bits are 11
  function automatic addrT instrLen(logic [1:0] low);
    return (low == 2'b11) ? 32'd4 : 32'd2;
  endfunction

  task automatic putHalf(addrT a, logic [15:0] h);
    if (a[1]) begin
      mem[a[9:2]][31:16] = h;
    end else begin
      mem[a[9:2]][15:0] = h;
    end
  endtask

  task automatic stopRun();
    $display("Something failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      stopRun();
    end
  endtask

  // inputs change 1 ns after the edge when the outputs have settled
  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic loadProgram();
    addrT a;
    a = ResetVector;
    for (int i = 0; i < 256; i++) begin
      mem[i] = nextRandom();
    end
    for (int i = 0; i < 6; i++) begin
      putHalf(a, prog[i][15:0]);
      if (prog[i][1:0] == 2'b11) begin
        putHalf(a + 32'd2, prog[i][31:16]);
      end
      a = a + instrLen(prog[i][1:0]);
    end
  endtask

  // one-cycle execute redirect
  task automatic branchTo(addrT target);
    pcSrcE    = 1'b1;
    pcTargetE = target;
    nextCycle();
    pcSrcE    = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic testSequential();
    addrT expPc;
    expPc = ResetVector;
    for (int i = 0; i < 6; i++) begin
      checkVal("pcF", pcF, expPc);
      expPc = expPc + instrLen(prog[i][1:0]);
      nextCycle();
      // 32-bit ones pass decode untouched with the spill half included
      if (prog[i][1:0] == 2'b11) begin
        checkVal("instrD", instrD, prog[i]);
      end
    end
    checkVal("pcF", pcF, expPc);
  endtask

  task automatic testRedirect();
    addrT br;
    addrT priv;
    br   = ResetVector | (nextRandom() & 32'h3fe);
    priv = ResetVector | (nextRandom() & 32'h3fe);
    // odd branch target drops to the halfword below
    branchTo(br | 32'h1);
    checkVal("pcF", pcF, br);
    // return beats a branch in the same cycle
    pcSrcE      = 1'b1;
    pcTargetE   = br;
    retM        = 1'b1;
    privNextPcM = priv;
    nextCycle();
    checkVal("pcF", pcF, priv);
    retM        = 1'b0;
    trapM       = 1'b1;
    privNextPcM = priv ^ 32'h104;
    nextCycle();
    checkVal("pcF", pcF, priv ^ 32'h104);
    trapM  = 1'b0;
    pcSrcE = 1'b0;
  endtask

  task automatic checkExpand(logic [15:0] half, instrT exp, logic illegal);
    putHalf(DecAddr, half);
    branchTo(DecAddr);
    nextCycle();
    checkVal("instrD", instrD, exp);
    checkVal("illegalInstrD", 32'(illegalInstrD), 32'(illegal));
  endtask

  task automatic testDecompress();
    checkExpand(16'h0085, 32'h00108093, 1'b0);  // c.addi x1,1
    checkExpand(16'h117d, 32'hfff10113, 1'b0);  // c.addi x2,-1
    checkExpand(16'h0001, NopInstr,     1'b0);  // c.nop
    checkExpand(16'h52f5, 32'hffd00293, 1'b0);  // c.li x5,-3
    checkExpand(16'h6185, 32'h000011b7, 1'b0);  // c.lui x3,1
    checkExpand(16'h727d, 32'hfffff237, 1'b0);  // c.lui x4,0xfffff
    checkExpand(16'h4144, 32'h00452483, 1'b0);  // c.lw x9,4(x10)
    checkExpand(16'h5fe0, 32'h07c7a403, 1'b0);  // c.lw x8,124(x15)
    checkExpand(16'hc60c, 32'h00b62423, 1'b0);  // c.sw x11,8(x12)
    checkExpand(16'ha021, 32'h0080006f, 1'b0);  // c.j 8
    checkExpand(16'hbffd, 32'hfffff06f, 1'b0);  // c.j -2
    checkExpand(16'hc011, 32'h00040263, 1'b0);  // c.beqz x8,4
    checkExpand(16'hfcf5, 32'hfe049ee3, 1'b0);  // c.bnez x9,-4
    checkExpand(16'h829a, 32'h006002b3, 1'b0);  // c.mv x5,x6
    checkExpand(16'h93a2, 32'h008383b3, 1'b0);  // c.add x7,x8
    // reserved or outside the subset
    checkExpand(16'h0000, NopInstr, 1'b1);
    checkExpand(16'h8002, NopInstr, 1'b1);
    checkExpand(16'h6181, NopInstr, 1'b1);
    checkExpand(16'h9002, NopInstr, 1'b1);
    checkExpand(16'h2004, NopInstr, 1'b1);
    checkExpand(16'h8082, 32'h00008067, 1'b0);  // c.jr x1
    // base decoder flag on its own
    illegalBaseD = 1'b1;
    #1;
    checkVal("illegalInstrD", 32'(illegalInstrD), 32'd1);
    illegalBaseD = 1'b0;
  endtask

  task automatic testPipeline();
    addrT        pcHist [0:15];
    addrT        lenHist [0:15];
    instrT       dHist [0:15];
    addrT        expPc;
    logic [15:0] half;
    branchTo(ResetVector);
    expPc = ResetVector;
    for (int t = 0; t < 16; t++) begin
      checkVal("pcF", pcF, expPc);
      pcHist[t]  = expPc;
      half       = halfAt(expPc);
      lenHist[t] = instrLen(half[1:0]);
      dHist[t]   = instrD;
      if (t >= 2) checkVal("instrM", instrM, dHist[t-2]);
      if (t >= 3) checkVal("pcM", pcM, pcHist[t-3]);
      if (t >= 4) checkVal("pcLinkW", pcLinkW, pcHist[t-4] + lenHist[t-4]);
      expPc = expPc + lenHist[t];
      nextCycle();
    end
  endtask

  // stalls F up to the given stage where 0 is F and 4 is W
  task automatic holdStages(int last);
    addrT  pcFSnap, pcESnap, pcMSnap, linkSnap;
    instrT dSnap, mSnap;
    stallF   = 1'b1;
    stallD   = (last >= 1);
    stallE   = (last >= 2);
    stallM   = (last >= 3);
    stallW   = (last >= 4);
    pcFSnap  = pcF;
    dSnap    = instrD;
    pcESnap  = pcE;
    pcMSnap  = pcM;
    mSnap    = instrM;
    linkSnap = pcLinkW;
    repeat (3) begin
      nextCycle();
      checkVal("pcF", pcF, pcFSnap);
      if (last >= 1) checkVal("instrD", instrD, dSnap);
      if (last >= 2) checkVal("pcE", pcE, pcESnap);
      if (last >= 3) checkVal("pcM", pcM, pcMSnap);
      if (last >= 3) checkVal("instrM", instrM, mSnap);
      if (last >= 4) checkVal("pcLinkW", pcLinkW, linkSnap);
    end
    {stallF, stallD, stallE, stallM, stallW} = '0;
    nextCycle();
  endtask

  task automatic testFlush();
    for (int s = 1; s <= 4; s++) begin
      // the first program word reaches stage s on the s-th edge after the redirect
      branchTo(ResetVector);
      repeat (s - 1) nextCycle();
      flushD = (s == 1);
      flushE = (s == 2);
      flushM = (s == 3);
      flushW = (s == 4);
      nextCycle();
      {flushD, flushE, flushM, flushW} = '0;
      if (s == 1) checkVal("instrD", instrD, NopInstr);
      if (s == 2) checkVal("pcE", pcE, 32'h0);
      if (s == 3) checkVal("instrM", instrM, NopInstr);
      if (s == 3) checkVal("pcM", pcM, 32'h0);
      if (s == 4) checkVal("pcLinkW", pcLinkW, 32'h0);
    end
  endtask

  task automatic testMisaligned();
    addrT tgt;
    tgt = ResetVector | (nextRandom() & 32'h3fe);
    branchTo(tgt | 32'h1);
    checkVal("instrMisalignedFaultM", 32'(instrMisalignedFaultM), 32'd1);
    checkVal("instrMisalignedAdrM", instrMisalignedAdrM, tgt);
    checkVal("pcF", pcF, tgt);
    branchTo(tgt ^ 32'h8);
    checkVal("instrMisalignedFaultM", 32'(instrMisalignedFaultM), 32'd0);
    // odd trap target next to a branch is not reported
    trapM       = 1'b1;
    privNextPcM = tgt | 32'h1;
    branchTo(tgt);
    trapM       = 1'b0;
    checkVal("instrMisalignedFaultM", 32'(instrMisalignedFaultM), 32'd0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst = 1'b1;
    {stallF, stallD, stallE, stallM, stallW} = '0;
    {flushD, flushE, flushM, flushW} = '0;
    {pcSrcE, retM, trapM, illegalBaseD} = '0;
    pcTargetE   = '0;
    privNextPcM = '0;
    loadProgram();
    repeat (10) nextCycle();
    rst = 1'b0;
    checkVal("pcF", pcF, ResetVector);
    checkVal("instrD", instrD, NopInstr);
    checkVal("instrM", instrM, NopInstr);
    testSequential();
    testRedirect();
    testDecompress();
    testPipeline();
    for (int s = 0; s < 5; s++) begin
      holdStages(s);
    end
    testFlush();
    testMisaligned();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
src/fetchPkg.sv
src/pipeCtrlIf.sv
src/pcSelect.sv
src/instrAlign.sv
src/decompress.sv
src/stagePipe.sv
src/ifu.sv
src/fetchTop.sv
sim/fetchTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the fetch subsystem testbench with Verilator and run it
# the exit status is nonzero when the build fails or the run hits $fatal

cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal --top-module fetchTb \
    -Mdir obj_dir -o fetchSim -f project.f &&
  ./obj_dir/fetchSim ||
  { echo "build or simulation did not complete cleanly"; exit 1; }
